// ==== Makefile ====
# Verilator build of the execution core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Simulation finished: PASS

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard source/*.sv source/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Output goes to the terminal, grep sets the exit status
run: compile
	./$(SIM) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
+incdir+source
source/isa_pkg.sv
source/exec_pkg.sv
source/control_logic.sv
source/reg_file.sv
source/alu.sv
source/pc_unit.sv
source/data_mem.sv
source/core_top.sv
tb/core_checker.sv
tb/tb_top.sv

// ==== source/alu.sv ====
// Arithmetic and logic unit
`include "core_config.svh"

module alu (
	input  exec_pkg::alu_op_t       alu_op,
	input  logic                    alu_src,
	input  logic                    sign_ext_sel,
	input  logic                    load_half,
	input  logic                    half_spec,
	input  logic                    call,
	input  logic                    rtrn,
	input  logic [`DATA_WIDTH-1:0]  opnd_a,
	input  logic [`DATA_WIDTH-1:0]  opnd_b,
	input  logic [7:0]              imm,
	output logic [`DATA_WIDTH-1:0]  result,
	output exec_pkg::flags_t        flags_next
);

	localparam int MSB  = `DATA_WIDTH - 1;
	localparam int SH_W = $clog2(`DATA_WIDTH);

	logic [`DATA_WIDTH-1:0] imm_ext;
	logic [`DATA_WIDTH-1:0] op_b;
	logic [`DATA_WIDTH-1:0] alu_out;
	logic                   ovf;

	// 4-bit immediate of INC, LW and SW
	assign imm_ext = sign_ext_sel ? {{(`DATA_WIDTH-4){imm[3]}}, imm[3:0]}
	                              : {{(`DATA_WIDTH-4){1'b0}}, imm[3:0]};

	always_comb begin
		if (call)
			op_b = '1;                                  // SP - 1
		else if (rtrn)
			op_b = {{(`DATA_WIDTH-1){1'b0}}, 1'b1};     // SP + 1
		else if (alu_src)
			op_b = imm_ext;
		else
			op_b = opnd_b;
	end

	always_comb begin
		ovf = 1'b0;
		case (alu_op)
			exec_pkg::ALU_ADD, exec_pkg::ALU_INC: begin
				alu_out = opnd_a + op_b;
				ovf     = (opnd_a[MSB] == op_b[MSB]) && (alu_out[MSB] != opnd_a[MSB]);
			end
			exec_pkg::ALU_SUB: begin
				alu_out = opnd_a - op_b;
				ovf     = (opnd_a[MSB] != op_b[MSB]) && (alu_out[MSB] != opnd_a[MSB]);
			end
			exec_pkg::ALU_NAND: alu_out = ~(opnd_a & op_b);
			exec_pkg::ALU_XOR:  alu_out = opnd_a ^ op_b;
			exec_pkg::ALU_SRA:  alu_out = $signed(opnd_a) >>> op_b[SH_W-1:0];
			exec_pkg::ALU_SRL:  alu_out = opnd_a >> op_b[SH_W-1:0];
			exec_pkg::ALU_SLL:  alu_out = opnd_a << op_b[SH_W-1:0];
			default:            alu_out = '0;
		endcase
	end

	// Byte merge into rd for LHB and LLB
	always_comb begin
		if (!load_half)
			result = alu_out;
		else if (half_spec)
			result = {opnd_b[MSB:8], imm};
		else
			result = {imm, opnd_b[7:0]};
	end

	assign flags_next[exec_pkg::FLAG_Z] = (result == '0);
	assign flags_next[exec_pkg::FLAG_N] = result[MSB];
	assign flags_next[exec_pkg::FLAG_V] = ovf;

endmodule

// ==== source/control_logic.sv ====
// Opcode decoder
module control_logic (
	input  isa_pkg::opcode_t  opcode,
	output logic              data_reg,     // Port 1 reads DS
	output logic              stack_reg,    // Port 1 reads SP, write goes to SP
	output logic              call,
	output logic              rtrn,
	output logic              branch,
	output logic              mem_to_reg,   // Load data to rd
	output exec_pkg::alu_op_t alu_op,
	output logic              alu_src,      // Immediate operand
	output logic              sign_ext_sel,
	output logic              reg_rt_src,   // Port 2 reads rd
	output logic              reg_write,
	output logic              mem_write,
	output logic              mem_read,
	output logic              load_half,
	output logic              half_spec,    // 0 LHB, 1 LLB
	output logic              flag_write
);

	always_comb begin
		// All-zero defaults leave ERR as a plain PC step
		data_reg     = 1'b0;
		stack_reg    = 1'b0;
		call         = 1'b0;
		rtrn         = 1'b0;
		branch       = 1'b0;
		mem_to_reg   = 1'b0;
		alu_op       = exec_pkg::ALU_ADD;
		alu_src      = 1'b0;
		sign_ext_sel = 1'b0;
		reg_rt_src   = 1'b0;
		reg_write    = 1'b0;
		mem_write    = 1'b0;
		mem_read     = 1'b0;
		load_half    = 1'b0;
		half_spec    = 1'b0;
		flag_write   = 1'b0;

		case (opcode)
			isa_pkg::ADD, isa_pkg::SUB, isa_pkg::NAND, isa_pkg::XOR,
			isa_pkg::SRA, isa_pkg::SRL, isa_pkg::SLL: begin
				alu_op     = exec_pkg::alu_op_t'(opcode[2:0]);
				reg_write  = 1'b1;
				flag_write = 1'b1;
			end
			isa_pkg::INC: begin
				alu_op       = exec_pkg::ALU_INC;
				alu_src      = 1'b1;
				sign_ext_sel = 1'b1;   // Signed step
				reg_write    = 1'b1;
				flag_write   = 1'b1;
			end
			isa_pkg::LW: begin
				data_reg   = 1'b1;
				alu_src    = 1'b1;
				mem_read   = 1'b1;
				mem_to_reg = 1'b1;
				reg_write  = 1'b1;
			end
			isa_pkg::SW: begin
				data_reg   = 1'b1;
				alu_src    = 1'b1;
				reg_rt_src = 1'b1;     // Store data is rd
				mem_write  = 1'b1;
			end
			isa_pkg::LHB, isa_pkg::LLB: begin
				reg_rt_src = 1'b1;
				load_half  = 1'b1;
				half_spec  = opcode[0];
				reg_write  = 1'b1;
			end
			isa_pkg::B:
				branch = 1'b1;
			isa_pkg::CALL: begin
				stack_reg = 1'b1;
				call      = 1'b1;
				mem_write = 1'b1;   // Push return address
				reg_write = 1'b1;   // SP - 1
			end
			isa_pkg::RET: begin
				stack_reg = 1'b1;
				rtrn      = 1'b1;
				mem_read  = 1'b1;
				reg_write = 1'b1;   // SP + 1
			end
			default: ;
		endcase
	end

endmodule

// ==== source/core_config.svh ====
// Core configuration
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Register and memory word width
`define DATA_WIDTH 16
`define REG_COUNT  16
`define MEM_DEPTH  256

// Dedicated registers
`define DS_REG     14
`define SP_REG     15

// Reset values of SP and DS
`define STACK_TOP  16'h00FF
`define DS_BASE    16'h0000

`endif

// ==== source/core_top.sv ====
// Execution core top level
`include "core_config.svh"

module core_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  isa_pkg::instr_t                 instr,
	input  logic                            instr_valid,
	output logic [`DATA_WIDTH-1:0]          pc,
	output logic                            wb_en,
	output logic [$clog2(`REG_COUNT)-1:0]   wb_addr,
	output logic [`DATA_WIDTH-1:0]          wb_data,
	output logic                            mem_we,
	output logic [$clog2(`MEM_DEPTH)-1:0]   mem_addr,
	output logic [`DATA_WIDTH-1:0]          mem_wdata
);

	localparam int RAW = $clog2(`REG_COUNT);

	logic                   data_reg;
	logic                   stack_reg;
	logic                   call;
	logic                   rtrn;
	logic                   branch;
	logic                   mem_to_reg;
	exec_pkg::alu_op_t      alu_op;
	logic                   alu_src;
	logic                   sign_ext_sel;
	logic                   reg_rt_src;
	logic                   reg_write;
	logic                   mem_write;
	logic                   mem_read;
	logic                   load_half;
	logic                   half_spec;
	logic                   flag_write;
	logic [`DATA_WIDTH-1:0] rd_data_1;
	logic [`DATA_WIDTH-1:0] rd_data_2;
	logic [`DATA_WIDTH-1:0] alu_result;
	logic [`DATA_WIDTH-1:0] rdata;
	exec_pkg::flags_t       flags_next;

	// Writes only commit with a valid instruction
	assign wb_en   = reg_write && instr_valid;
	assign mem_we  = mem_write && instr_valid;
	assign wb_addr = stack_reg ? RAW'(`SP_REG) : instr[11:8];

	control_logic u_ctrl (
		.opcode(isa_pkg::opcode_t'(instr[15:12])), .data_reg(data_reg),
		.stack_reg(stack_reg), .call(call), .rtrn(rtrn), .branch(branch),
		.mem_to_reg(mem_to_reg), .alu_op(alu_op), .alu_src(alu_src),
		.sign_ext_sel(sign_ext_sel), .reg_rt_src(reg_rt_src), .reg_write(reg_write),
		.mem_write(mem_write), .mem_read(mem_read), .load_half(load_half),
		.half_spec(half_spec), .flag_write(flag_write)
	);

	reg_file u_regs (
		.clk(clk), .rst_n(rst_n), .rs(instr[7:4]), .rt(instr[3:0]), .rd(instr[11:8]),
		.data_reg(data_reg), .stack_reg(stack_reg), .reg_rt_src(reg_rt_src),
		.reg_write(wb_en), .wr_data(wb_data), .rd_data_1(rd_data_1), .rd_data_2(rd_data_2)
	);

	alu u_alu (
		.alu_op(alu_op), .alu_src(alu_src), .sign_ext_sel(sign_ext_sel),
		.load_half(load_half), .half_spec(half_spec), .call(call), .rtrn(rtrn),
		.opnd_a(rd_data_1), .opnd_b(rd_data_2), .imm(instr[7:0]),
		.result(alu_result), .flags_next(flags_next)
	);

	// Flags are only seen through branches
	pc_unit u_pc (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .branch(branch),
		.call(call), .rtrn(rtrn), .flag_write(flag_write),
		.cond(isa_pkg::cond_t'(instr[11:9])), .offset(instr[11:0]),
		.flags_next(flags_next), .ret_addr(rdata), .pc(pc), .flags()
	);

	data_mem u_dmem (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .mem_write(mem_write),
		.mem_read(mem_read), .mem_to_reg(mem_to_reg), .call(call),
		.alu_result(alu_result), .sp_value(rd_data_1), .wdata_reg(rd_data_2), .pc(pc),
		.rdata(rdata), .wb_data(wb_data), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

endmodule

// ==== source/data_mem.sv ====
// Data memory and write-back select
`include "core_config.svh"

module data_mem (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            instr_valid,
	input  logic                            mem_write,
	input  logic                            mem_read,
	input  logic                            mem_to_reg,
	input  logic                            call,
	input  logic [`DATA_WIDTH-1:0]          alu_result,
	input  logic [`DATA_WIDTH-1:0]          sp_value,
	input  logic [`DATA_WIDTH-1:0]          wdata_reg,
	input  logic [`DATA_WIDTH-1:0]          pc,
	output logic [`DATA_WIDTH-1:0]          rdata,
	output logic [`DATA_WIDTH-1:0]          wb_data,
	output logic [$clog2(`MEM_DEPTH)-1:0]   mem_addr,
	output logic [`DATA_WIDTH-1:0]          mem_wdata
);

	localparam int AW = $clog2(`MEM_DEPTH);

	logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

	// Push goes to the old SP, address wraps at memory depth
	assign mem_addr  = call ? sp_value[AW-1:0] : alu_result[AW-1:0];
	assign mem_wdata = call ? pc + 1'b1 : wdata_reg;   // Return address
	assign rdata     = mem_read ? mem[mem_addr] : '0;
	assign wb_data   = mem_to_reg ? rdata : alu_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `MEM_DEPTH; i++)
				mem[i] <= '0;
		end else if (instr_valid && mem_write) begin
			mem[mem_addr] <= mem_wdata;
		end
	end

endmodule

// ==== source/exec_pkg.sv ====
// Datapath execution types
package exec_pkg;

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_NAND = 3'd2,
		ALU_XOR  = 3'd3,
		ALU_INC  = 3'd4,
		ALU_SRA  = 3'd5,
		ALU_SRL  = 3'd6,
		ALU_SLL  = 3'd7
	} alu_op_t;

	// Zero, negative, overflow
	typedef logic [2:0] flags_t;

	localparam int FLAG_Z = 2;
	localparam int FLAG_N = 1;
	localparam int FLAG_V = 0;

endpackage

// ==== source/isa_pkg.sv ====
// Instruction set types
package isa_pkg;

	// Low three bits of the ALU opcodes select the ALU operation
	typedef enum logic [3:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		NAND = 4'h2,
		XOR  = 4'h3,
		INC  = 4'h4,
		SRA  = 4'h5,
		SRL  = 4'h6,
		SLL  = 4'h7,
		LW   = 4'h8,
		SW   = 4'h9,
		LHB  = 4'hA,
		LLB  = 4'hB,
		B    = 4'hC,
		CALL = 4'hD,
		RET  = 4'hE,
		ERR  = 4'hF
	} opcode_t;

	// Branch conditions in bits 11..9
	typedef enum logic [2:0] {
		EQ = 3'b000,
		LT = 3'b001,
		GT = 3'b010,
		OV = 3'b011,
		NE = 3'b100,
		GE = 3'b101,
		LE = 3'b110,
		TR = 3'b111   // Always taken
	} cond_t;

	// Instruction word, opcode in 15..12
	typedef logic [15:0] instr_t;

endpackage

// ==== source/pc_unit.sv ====
// Program counter and flags
`include "core_config.svh"

module pc_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    instr_valid,
	input  logic                    branch,
	input  logic                    call,
	input  logic                    rtrn,
	input  logic                    flag_write,
	input  isa_pkg::cond_t          cond,
	input  logic [11:0]             offset,
	input  exec_pkg::flags_t        flags_next,
	input  logic [`DATA_WIDTH-1:0]  ret_addr,
	output logic [`DATA_WIDTH-1:0]  pc,
	output exec_pkg::flags_t        flags
);

	logic [`DATA_WIDTH-1:0] pc_inc;
	logic [`DATA_WIDTH-1:0] br_target;
	logic [`DATA_WIDTH-1:0] call_target;
	logic [`DATA_WIDTH-1:0] pc_next;
	logic                   z;
	logic                   n;
	logic                   v;
	logic                   taken;

	assign pc_inc      = pc + 1'b1;
	assign br_target   = pc_inc + {{(`DATA_WIDTH-9){offset[8]}}, offset[8:0]};   // 9-bit offset
	assign call_target = pc_inc + {{(`DATA_WIDTH-12){offset[11]}}, offset};

	assign z = flags[exec_pkg::FLAG_Z];
	assign n = flags[exec_pkg::FLAG_N];
	assign v = flags[exec_pkg::FLAG_V];

	always_comb begin
		case (cond)
			isa_pkg::EQ: taken = z;
			isa_pkg::LT: taken = n;
			isa_pkg::GT: taken = !z && !n;
			isa_pkg::OV: taken = v;
			isa_pkg::NE: taken = !z;
			isa_pkg::GE: taken = !n;
			isa_pkg::LE: taken = n || z;
			default:     taken = 1'b1;   // TR
		endcase
	end

	always_comb begin
		if (rtrn)
			pc_next = ret_addr;   // Popped from stack
		else if (call)
			pc_next = call_target;
		else if (branch && taken)
			pc_next = br_target;
		else
			pc_next = pc_inc;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc    <= '0;
			flags <= '0;
		end else if (instr_valid) begin
			pc <= pc_next;
			if (flag_write)
				flags <= flags_next;
		end
	end

endmodule

// ==== source/reg_file.sv ====
// Register file
`include "core_config.svh"

module reg_file (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [$clog2(`REG_COUNT)-1:0]    rs,
	input  logic [$clog2(`REG_COUNT)-1:0]    rt,
	input  logic [$clog2(`REG_COUNT)-1:0]    rd,
	input  logic                             data_reg,
	input  logic                             stack_reg,
	input  logic                             reg_rt_src,
	input  logic                             reg_write,
	input  logic [`DATA_WIDTH-1:0]           wr_data,
	output logic [`DATA_WIDTH-1:0]           rd_data_1,
	output logic [`DATA_WIDTH-1:0]           rd_data_2
);

	localparam int RAW = $clog2(`REG_COUNT);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
	logic [RAW-1:0]         rd_idx_1;
	logic [RAW-1:0]         rd_idx_2;
	logic [RAW-1:0]         wr_idx;

	always_comb begin
		if (stack_reg)
			rd_idx_1 = RAW'(`SP_REG);
		else if (data_reg)
			rd_idx_1 = RAW'(`DS_REG);   // Base for LW and SW
		else
			rd_idx_1 = rs;
	end

	assign rd_idx_2  = reg_rt_src ? rd : rt;
	assign wr_idx    = stack_reg ? RAW'(`SP_REG) : rd;
	assign rd_data_1 = regs[rd_idx_1];
	assign rd_data_2 = regs[rd_idx_2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
			regs[`DS_REG] <= `DS_BASE;
			regs[`SP_REG] <= `STACK_TOP;
		end else if (reg_write && wr_idx != '0) begin   // r0 stays zero
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

// ==== tb/core_checker.sv ====
// Core reference checker
`include "core_config.svh"

module core_checker (
	input  logic                            clk,
	input  logic                            rst_n,
	input  isa_pkg::instr_t                 instr,
	input  logic                            instr_valid,
	input  logic [2:0]                      test_id,
	input  logic [`DATA_WIDTH-1:0]          pc,
	input  logic                            wb_en,
	input  logic [$clog2(`REG_COUNT)-1:0]   wb_addr,
	input  logic [`DATA_WIDTH-1:0]          wb_data,
	input  logic                            mem_we,
	input  logic [$clog2(`MEM_DEPTH)-1:0]   mem_addr,
	input  logic [`DATA_WIDTH-1:0]          mem_wdata,
	output int                              err_count,
	output int                              check_count
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [15:0] m_regs [16];
	logic [15:0] m_mem [256];
	logic [15:0] m_pc;
	logic        m_z, m_n, m_v;
	logic [2:0]  last_id;
	int          test_errs;
	int          test_checks;

	logic [15:0] e_pc, e_wb_data, e_mem_wdata;
	logic [3:0]  e_wb_addr;
	logic [7:0]  e_mem_addr;
	logic        e_wb_en, e_mem_we, e_fl_we, e_z, e_n, e_v;

	function automatic string test_label(input logic [2:0] id);
		case (id)
			3'd0: return "alu_ops";
			3'd1: return "load_store";
			3'd2: return "load_half";
			3'd3: return "branches";
			3'd4: return "call_return";
			3'd5: return "idle_cycles";
			default: return "random";
		endcase
	endfunction

	// Expected outputs and next state from the instruction set rules
	function automatic void predict(input logic [15:0] ins);
		logic [3:0]  op, rd, rs, rt;
		logic [15:0] a, b, r, sext4;
		int          s;
		logic        taken;
		op = ins[15:12];
		rd = ins[11:8];
		rs = ins[7:4];
		rt = ins[3:0];
		a = m_regs[rs];
		b = m_regs[rt];
		sext4 = {{12{ins[3]}}, ins[3:0]};
		r = 16'd0;
		s = 0;
		taken = 1'b0;
		e_pc = m_pc + 16'd1;
		e_wb_en = 1'b0;
		e_wb_addr = rd;
		e_wb_data = 16'd0;
		e_mem_we = 1'b0;
		e_mem_addr = 8'd0;
		e_mem_wdata = 16'd0;
		e_fl_we = 1'b0;
		e_z = 1'b0;
		e_n = 1'b0;
		e_v = 1'b0;
		case (op)
			4'h0: begin
				r = a + b;
				s = int'($signed(a)) + int'($signed(b));
			end
			4'h1: begin
				r = a - b;
				s = int'($signed(a)) - int'($signed(b));
			end
			4'h2: r = ~(a & b);
			4'h3: r = a ^ b;
			4'h4: begin
				r = a + sext4;
				s = int'($signed(a)) + int'($signed(sext4));
			end
			4'h5: r = 16'($signed(a) >>> b[3:0]);
			4'h6: r = a >> b[3:0];
			4'h7: r = a << b[3:0];
			4'h8: begin
				e_mem_addr = 8'(m_regs[`DS_REG] + {12'd0, ins[3:0]});
				e_wb_en = 1'b1;
				e_wb_data = m_mem[e_mem_addr];
			end
			4'h9: begin
				e_mem_addr = 8'(m_regs[`DS_REG] + {12'd0, ins[3:0]});
				e_mem_we = 1'b1;
				e_mem_wdata = m_regs[rd];
			end
			4'hA: begin
				e_wb_en = 1'b1;
				e_wb_data = {ins[7:0], m_regs[rd][7:0]};
			end
			4'hB: begin
				e_wb_en = 1'b1;
				e_wb_data = {m_regs[rd][15:8], ins[7:0]};
			end
			4'hC: begin
				case (ins[11:9])
					3'd0: taken = m_z;
					3'd1: taken = m_n;
					3'd2: taken = !m_z && !m_n;
					3'd3: taken = m_v;
					3'd4: taken = !m_z;
					3'd5: taken = !m_n;
					3'd6: taken = m_n || m_z;
					default: taken = 1'b1;
				endcase
				if (taken)
					e_pc = m_pc + 16'd1 + {{7{ins[8]}}, ins[8:0]};
			end
			4'hD: begin
				e_mem_we = 1'b1;
				e_mem_addr = m_regs[`SP_REG][7:0];
				e_mem_wdata = m_pc + 16'd1;
				e_wb_en = 1'b1;
				e_wb_addr = 4'(`SP_REG);
				e_wb_data = m_regs[`SP_REG] - 16'd1;
				e_pc = m_pc + 16'd1 + {{4{ins[11]}}, ins[11:0]};
			end
			4'hE: begin
				e_wb_en = 1'b1;
				e_wb_addr = 4'(`SP_REG);
				e_wb_data = m_regs[`SP_REG] + 16'd1;
				e_pc = m_mem[8'(m_regs[`SP_REG] + 16'd1)];
			end
			default: ;
		endcase
		if (op < 4'h8) begin   // ALU group
			e_wb_en = 1'b1;
			e_wb_data = r;
			e_fl_we = 1'b1;
			e_z = (r == 16'd0);
			e_n = r[15];
			e_v = (s > 32767) || (s < -32768);
		end
	endfunction

	task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
		check_count++;
		test_checks++;
		if (exp !== act) begin
			err_count++;
			test_errs++;
			$display("MISMATCH %s %s expected %h actual %h", test_label(last_id), what, exp, act);
		end
	endtask

	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				m_regs[i] = 16'd0;
			m_regs[`DS_REG] = `DS_BASE;
			m_regs[`SP_REG] = `STACK_TOP;
			for (int i = 0; i < 256; i++)
				m_mem[i] = 16'd0;
			m_pc = 16'd0;
			{m_z, m_n, m_v} = 3'b000;
			last_id = 3'd0;
			test_errs = 0;
			test_checks = 0;
			err_count = 0;
			check_count = 0;
		end else begin
			if (test_id != last_id) begin   // Previous test is done
				$display("%s: %0d checks, %0d mismatches", test_label(last_id),
					test_checks, test_errs);
				last_id = test_id;
				test_errs = 0;
				test_checks = 0;
			end
			compare("pc", m_pc, pc);
			if (instr_valid) begin
				predict(instr);
				compare("wb_en", {15'd0, e_wb_en}, {15'd0, wb_en});
				compare("mem_we", {15'd0, e_mem_we}, {15'd0, mem_we});
				if (e_wb_en) begin
					compare("wb_addr", {12'd0, e_wb_addr}, {12'd0, wb_addr});
					compare("wb_data", e_wb_data, wb_data);
				end
				if (e_mem_we) begin
					compare("mem_addr", {8'd0, e_mem_addr}, {8'd0, mem_addr});
					compare("mem_wdata", e_mem_wdata, mem_wdata);
				end
				if (e_wb_en && e_wb_addr != 4'd0)
					m_regs[e_wb_addr] = e_wb_data;
				if (e_mem_we)
					m_mem[e_mem_addr] = e_mem_wdata;
				if (e_fl_we)
					{m_z, m_n, m_v} = {e_z, e_n, e_v};
				m_pc = e_pc;
			end else begin
				compare("wb_en idle", 16'd0, {15'd0, wb_en});
				compare("mem_we idle", 16'd0, {15'd0, mem_we});
			end
		end
	end

endmodule

// ==== tb/tb_top.sv ====
// Execution core testbench
`include "core_config.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DIRECTED_LEN = 130;   // Upper bound incl. test boundaries
	localparam int RANDOM_LEN   = 300;
	localparam int WATCHDOG_CYC = 4 + DIRECTED_LEN + RANDOM_LEN + 50;

	logic                            clk;
	logic                            rst_n;
	isa_pkg::instr_t                 instr;
	logic                            instr_valid;
	logic [2:0]                      test_id;
	logic [`DATA_WIDTH-1:0]          pc;
	logic                            wb_en;
	logic [$clog2(`REG_COUNT)-1:0]   wb_addr;
	logic [`DATA_WIDTH-1:0]          wb_data;
	logic                            mem_we;
	logic [$clog2(`MEM_DEPTH)-1:0]   mem_addr;
	logic [`DATA_WIDTH-1:0]          mem_wdata;
	int                              err_count;
	int                              check_count;

	core_top dut (
		.clk(clk), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid), .pc(pc),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	core_checker u_checker (
		.clk(clk), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
		.test_id(test_id), .pc(pc), .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.err_count(err_count), .check_count(check_count)
	);

	always #20 clk = ~clk;

	function automatic isa_pkg::instr_t enc_r(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic isa_pkg::instr_t enc_h(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	task automatic issue(input isa_pkg::instr_t ins);
		@(posedge clk);
		instr <= ins;
		instr_valid <= 1'b1;
	endtask

	task automatic idle(input isa_pkg::instr_t ins);
		@(posedge clk);
		instr <= ins;   // Must be ignored
		instr_valid <= 1'b0;
	endtask

	task automatic start_test(input logic [2:0] id);
		@(posedge clk);
		test_id <= id;
		instr_valid <= 1'b0;
	endtask

	initial begin
		void'($urandom(23));
		clk = 1'b0;
		rst_n = 1'b0;
		instr = 16'd0;
		instr_valid = 1'b0;
		test_id = 3'd0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		start_test(3'd0);
		issue(enc_h(isa_pkg::LLB, 4'd1, 8'h34));
		issue(enc_h(isa_pkg::LHB, 4'd1, 8'h12));
		issue(enc_h(isa_pkg::LLB, 4'd2, 8'h03));
		issue(enc_r(isa_pkg::ADD, 4'd3, 4'd1, 4'd2));
		issue(enc_r(isa_pkg::SUB, 4'd4, 4'd2, 4'd1));
		issue(enc_r(isa_pkg::NAND, 4'd5, 4'd1, 4'd2));
		issue(enc_r(isa_pkg::XOR, 4'd6, 4'd1, 4'd2));
		issue(enc_r(isa_pkg::INC, 4'd7, 4'd1, 4'hE));
		issue(enc_r(isa_pkg::SRA, 4'd8, 4'd4, 4'd2));
		issue(enc_r(isa_pkg::SRL, 4'd9, 4'd4, 4'd2));
		issue(enc_r(isa_pkg::SLL, 4'd10, 4'd1, 4'd2));
		issue(enc_h(isa_pkg::LLB, 4'd11, 8'hFF));
		issue(enc_h(isa_pkg::LHB, 4'd11, 8'h7F));
		issue(enc_r(isa_pkg::INC, 4'd12, 4'd11, 4'd1));   // 0x7FFF + 1 overflows
		issue({4'hC, 3'd3, 9'd2});
		issue(enc_r(isa_pkg::SUB, 4'd13, 4'd11, 4'd11));
		issue({4'hC, 3'd0, 9'd4});

		start_test(3'd1);
		issue(enc_r(isa_pkg::SW, 4'd1, 4'd0, 4'd3));
		issue(enc_r(isa_pkg::LW, 4'd13, 4'd0, 4'd3));
		issue(enc_h(isa_pkg::LLB, 4'd14, 8'h10));
		issue(enc_r(isa_pkg::SW, 4'd3, 4'd0, 4'd15));
		issue(enc_r(isa_pkg::LW, 4'd12, 4'd0, 4'd15));
		issue(enc_h(isa_pkg::LLB, 4'd14, 8'h00));
		issue(enc_r(isa_pkg::LW, 4'd0, 4'd0, 4'd3));
		issue(enc_r(isa_pkg::ADD, 4'd6, 4'd0, 4'd0));

		start_test(3'd2);
		issue(enc_h(isa_pkg::LLB, 4'd5, 8'hAB));
		issue(enc_h(isa_pkg::LHB, 4'd5, 8'hCD));
		issue(enc_h(isa_pkg::LHB, 4'd1, 8'hFF));
		issue(enc_h(isa_pkg::LLB, 4'd1, 8'h00));
		issue(enc_r(isa_pkg::ADD, 4'd6, 4'd5, 4'd0));

		// Each condition after zero, negative, positive and overflowed results
		start_test(3'd3);
		for (int c = 0; c < 8; c++) begin
			issue(enc_r(isa_pkg::SUB, 4'd13, 4'd1, 4'd1));
			issue({4'hC, 3'(c), 9'($urandom)});
			issue(enc_r(isa_pkg::XOR, 4'd13, 4'd1, 4'd0));
			issue({4'hC, 3'(c), 9'($urandom)});
			issue(enc_r(isa_pkg::ADD, 4'd13, 4'd2, 4'd2));
			issue({4'hC, 3'(c), 9'($urandom)});
			issue(enc_r(isa_pkg::INC, 4'd12, 4'd11, 4'd1));
			issue({4'hC, 3'(c), 9'($urandom)});
		end

		start_test(3'd4);
		issue({4'hD, 12'd10});
		issue({4'hD, 12'hFD8});   // Backward call
		issue(enc_r(isa_pkg::ADD, 4'd3, 4'd1, 4'd2));
		issue({4'hE, 12'd0});
		issue({4'hE, 12'd0});
		issue(enc_r(isa_pkg::ADD, 4'd4, 4'd15, 4'd0));   // SP back at top

		start_test(3'd5);
		issue(enc_r(isa_pkg::SW, 4'd5, 4'd0, 4'd7));
		idle(enc_r(isa_pkg::SW, 4'd3, 4'd0, 4'd7));   // Would overwrite mem[7]
		idle(enc_h(isa_pkg::LLB, 4'd9, 8'h5A));
		idle({4'hD, 12'd5});
		issue(enc_r(isa_pkg::LW, 4'd9, 4'd0, 4'd7));
		idle(enc_r(isa_pkg::INC, 4'd9, 4'd9, 4'd1));
		issue({4'hD, 12'd3});
		idle({4'hE, 12'd0});   // Would pop early
		issue({4'hE, 12'd0});
		repeat (2) idle(16'($urandom));
		issue(enc_r(isa_pkg::ADD, 4'd10, 4'd9, 4'd15));

		start_test(3'd6);
		for (int i = 0; i < RANDOM_LEN; i++) begin
			if ($urandom % 4 == 0)
				idle(16'($urandom));
			else
				issue(16'($urandom));
		end

		start_test(3'd7);
		repeat (2) @(posedge clk);
		$display("Totals: %0d checks, %0d mismatches", check_count, err_count);
		if (err_count == 0 && check_count > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("Watchdog expired before all tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
